//--- include/copper_settings.svh
//**************************************************************************
// copper build settings
// address and beam widths plus the idle fill words for program memory
//**************************************************************************

`ifndef COPPER_SETTINGS_SVH
`define COPPER_SETTINGS_SVH

// instruction address width, host word addresses are one bit wider
`define COPP_AWIDTH 10

// width of the horizontal and vertical beam counters
`define COPP_BEAM_W 11

// idle program word pair
// WAIT (opcode 0) for v=7ff, h=7ff which no real frame reaches,
// so an unloaded copper sits until the next frame start
`define COPP_INIT_EVEN 16'h07FF
`define COPP_INIT_ODD  16'h07FF

`endif

//--- rtl/copper_pkg.sv
//**************************************************************************
// copper shared types
// widths, opcode and state encodings, and the bundles between blocks
//**************************************************************************

`default_nettype none

`include "copper_settings.svh"

package copper_pkg;

    // one half of an instruction as held in each memory
    typedef logic [15:0] word_t;

    // full instruction, even half on top
    typedef logic [31:0] instr_t;

    // instruction index into program memory
    typedef logic [`COPP_AWIDTH-1:0] copp_addr_t;

    // host side 16-bit word address, bit 0 picks the half
    typedef logic [`COPP_AWIDTH:0] host_addr_t;

    // one beam counter
    typedef logic [`COPP_BEAM_W-1:0] beam_coord_t;

    // video register number written by MOVE
    typedef logic [7:0] reg_num_t;

    // opcode in instruction bits 31..28
    // WAIT has to stay at zero to match the idle fill words
    typedef enum logic [3:0] {
        WAIT = 4'h0,
        SKIP = 4'h1,
        MOVE = 4'h2,
        JUMP = 4'h3
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        FETCH     = 3'd1,
        DECODE    = 3'd2,
        EXEC_WAIT = 3'd3,
        EXEC_SKIP = 3'd4
    } ctrl_state_e;

    // v before h so that a packed compare orders by line first
    typedef struct packed {
        beam_coord_t v;
        beam_coord_t h;
    } beam_pos_t;

    // host write strobe into program memory
    typedef struct packed {
        logic       en;
        host_addr_t addr;
        word_t      data;
    } host_wr_t;

    // video register write strobe
    typedef struct packed {
        logic     valid;
        reg_num_t num;
        word_t    data;
    } reg_wr_t;

endpackage

`default_nettype wire

//--- rtl/coppermem.sv
//**************************************************************************
// copper memory half
// 16-bit block RAM with one write port and one registered read port,
// filled at start with the idle word for its half
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

`include "copper_settings.svh"

module coppermem #(
    // 0 holds upper instruction halves, 1 the lower ones
    parameter bit ODDWORD = 1'b0
) (
    input  wire logic                   clk,
    input  wire logic                   wr_en_i,
    input  wire copper_pkg::copp_addr_t wr_address_i,
    input  wire copper_pkg::word_t      wr_data_i,
    input  wire copper_pkg::copp_addr_t rd_address_i,
    output copper_pkg::word_t           rd_data_o
);

    localparam int DEPTH = 2 ** `COPP_AWIDTH;

    copper_pkg::word_t bram [0:DEPTH-1];

    // every slot starts as the idle WAIT so that any fetch is harmless
    initial begin
        for (int i = 0; i < DEPTH; i = i + 1) begin
            if (ODDWORD) begin
                bram[i] = `COPP_INIT_ODD;
            end else begin
                bram[i] = `COPP_INIT_EVEN;
            end
        end
    end

    // write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            bram[wr_address_i] <= wr_data_i;
        end
    end

    // read data arrives one cycle after the address
    always_ff @(posedge clk) begin
        rd_data_o <= bram[rd_address_i];
    end

endmodule

`default_nettype wire

//--- rtl/copper_prog_mem.sv
//**************************************************************************
// copper program memory
// two half memories behind one host word port and one instruction port
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

`include "copper_settings.svh"

module copper_prog_mem (
    input  wire logic                   clk,
    input  wire copper_pkg::host_wr_t   host_wr_i,
    input  wire copper_pkg::copp_addr_t fetch_addr_i,
    output copper_pkg::instr_t          instr_o
);

    logic                   even_wr_en;
    logic                   odd_wr_en;
    copper_pkg::copp_addr_t wr_index;
    copper_pkg::word_t      even_data;
    copper_pkg::word_t      odd_data;

    // host address bit 0 picks the half, the rest is the instruction index
    assign even_wr_en = host_wr_i.en & ~host_wr_i.addr[0];
    assign odd_wr_en  = host_wr_i.en &  host_wr_i.addr[0];
    assign wr_index   = host_wr_i.addr[`COPP_AWIDTH:1];

    coppermem #(.ODDWORD(1'b0)) even_mem_i (
        .clk          (clk),
        .wr_en_i      (even_wr_en),
        .wr_address_i (wr_index),
        .wr_data_i    (host_wr_i.data),
        .rd_address_i (fetch_addr_i),
        .rd_data_o    (even_data)
    );

    coppermem #(.ODDWORD(1'b1)) odd_mem_i (
        .clk          (clk),
        .wr_en_i      (odd_wr_en),
        .wr_address_i (wr_index),
        .wr_data_i    (host_wr_i.data),
        .rd_address_i (fetch_addr_i),
        .rd_data_o    (odd_data)
    );

    // even half is the upper word
    assign instr_o = {even_data, odd_data};

endmodule

`default_nettype wire

//--- rtl/copper_beam_cmp.sv
//**************************************************************************
// copper beam comparator
// registered at-or-past test against the current target, plus frame start
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

module copper_beam_cmp (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire copper_pkg::beam_pos_t beam_i,
    input  wire copper_pkg::beam_pos_t target_i,
    output logic                       reached_o,
    output logic                       frame_start_o
);

    logic                  at_or_past;
    logic                  beam_at_origin;
    copper_pkg::beam_pos_t prev_beam_q;

    // a later line counts regardless of h, the same line needs h at or past
    assign at_or_past = (beam_i.v > target_i.v) ||
                        ((beam_i.v == target_i.v) && (beam_i.h >= target_i.h));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            reached_o <= 1'b0;
        end else begin
            reached_o <= at_or_past;
        end
    end

    // previous position so the origin only pulses once per wrap
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            prev_beam_q <= '0;
        end else begin
            prev_beam_q <= beam_i;
        end
    end

    assign beam_at_origin = (beam_i.v == '0) && (beam_i.h == '0);
    assign frame_start_o  = beam_at_origin && (prev_beam_q != beam_i);

endmodule

`default_nettype wire

//--- rtl/copper_ctrl.sv
//**************************************************************************
// copper control
// program counter and instruction FSM running WAIT, SKIP, MOVE and JUMP,
// restarted at address 0 by every frame start while enabled
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

`include "copper_settings.svh"

module copper_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire logic                   enable_i,
    input  wire logic                   frame_start_i,
    input  wire logic                   reached_i,
    input  wire copper_pkg::instr_t     instr_i,
    output copper_pkg::copp_addr_t      fetch_addr_o,
    output copper_pkg::beam_pos_t       target_o,
    output copper_pkg::reg_wr_t         reg_wr_o
);

    copper_pkg::ctrl_state_e state_q;
    copper_pkg::copp_addr_t  pc_q;
    copper_pkg::copp_addr_t  pc_plus1;
    copper_pkg::copp_addr_t  pc_plus2;

    // decoded instruction fields
    copper_pkg::opcode_e     op;
    copper_pkg::beam_pos_t   instr_target;
    copper_pkg::reg_num_t    move_num;
    copper_pkg::word_t       move_data;
    copper_pkg::copp_addr_t  jump_addr;
    logic                    is_compare;

    // held target and register write payload
    copper_pkg::beam_pos_t   target_q;
    logic                    wr_valid_q;
    copper_pkg::reg_num_t    wr_num_q;
    copper_pkg::word_t       wr_data_q;

    assign op              = copper_pkg::opcode_e'(instr_i[31:28]);
    assign instr_target.v  = instr_i[16 +: `COPP_BEAM_W];
    assign instr_target.h  = instr_i[0 +: `COPP_BEAM_W];
    assign move_num        = instr_i[23:16];
    assign move_data       = instr_i[15:0];
    assign jump_addr       = instr_i[`COPP_AWIDTH-1:0];
    assign is_compare      = (op == copper_pkg::WAIT) || (op == copper_pkg::SKIP);

    assign pc_plus1 = pc_q + copper_pkg::copp_addr_t'(1);
    assign pc_plus2 = pc_q + copper_pkg::copp_addr_t'(2);

    // memory read is registered, so the instruction shows up in DECODE
    assign fetch_addr_o = pc_q;

    // the comparator sees the new target already during DECODE,
    // so reached is valid from the first execute cycle on
    assign target_o = (state_q == copper_pkg::DECODE && is_compare) ? instr_target : target_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q    <= copper_pkg::IDLE;
            pc_q       <= '0;
            wr_valid_q <= 1'b0;
        end else begin
            // write strobe lasts one cycle
            wr_valid_q <= 1'b0;

            if (!enable_i) begin
                state_q <= copper_pkg::IDLE;
                pc_q    <= '0;
            end else if (frame_start_i) begin
                // restart the program from any state
                state_q <= copper_pkg::FETCH;
                pc_q    <= '0;
            end else begin
                case (state_q)
                    copper_pkg::IDLE: begin
                        // hold until the next frame start
                        state_q <= copper_pkg::IDLE;
                    end
                    copper_pkg::FETCH: begin
                        state_q <= copper_pkg::DECODE;
                    end
                    copper_pkg::DECODE: begin
                        state_q <= copper_pkg::FETCH;
                        case (op)
                            copper_pkg::WAIT: begin
                                pc_q    <= pc_plus1;
                                state_q <= copper_pkg::EXEC_WAIT;
                            end
                            copper_pkg::SKIP: begin
                                state_q <= copper_pkg::EXEC_SKIP;
                            end
                            copper_pkg::MOVE: begin
                                pc_q       <= pc_plus1;
                                wr_valid_q <= 1'b1;
                            end
                            copper_pkg::JUMP: begin
                                pc_q <= jump_addr;
                            end
                            default: begin
                                // unknown opcodes act as a no-op
                                pc_q <= pc_plus1;
                            end
                        endcase
                    end
                    copper_pkg::EXEC_WAIT: begin
                        if (reached_i) begin
                            state_q <= copper_pkg::FETCH;
                        end
                    end
                    copper_pkg::EXEC_SKIP: begin
                        // target already passed means drop the next instruction
                        pc_q    <= reached_i ? pc_plus2 : pc_plus1;
                        state_q <= copper_pkg::FETCH;
                    end
                    default: begin
                        state_q <= copper_pkg::IDLE;
                    end
                endcase
            end
        end
    end

    // payload registers, only loaded while decoding
    always_ff @(posedge clk) begin
        if (state_q == copper_pkg::DECODE) begin
            if (is_compare) begin
                target_q <= instr_target;
            end
            if (op == copper_pkg::MOVE) begin
                wr_num_q  <= move_num;
                wr_data_q <= move_data;
            end
        end
    end

    assign reg_wr_o = '{valid: wr_valid_q, num: wr_num_q, data: wr_data_q};

endmodule

`default_nettype wire

//--- rtl/copper_top.sv
//**************************************************************************
// copper top level
// display list coprocessor issuing video register writes at beam positions
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

module copper_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire logic                  enable_i,
    input  wire copper_pkg::beam_pos_t beam_i,
    input  wire copper_pkg::host_wr_t  host_wr_i,
    output copper_pkg::reg_wr_t        reg_wr_o
);

    copper_pkg::copp_addr_t fetch_addr;
    copper_pkg::instr_t     instr;
    copper_pkg::beam_pos_t  target;
    logic                   reached;
    logic                   frame_start;

    // host writes and instruction fetch share one clock
    copper_prog_mem prog_mem_i (
        .clk          (clk),
        .host_wr_i    (host_wr_i),
        .fetch_addr_i (fetch_addr),
        .instr_o      (instr)
    );

    copper_beam_cmp beam_cmp_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .beam_i        (beam_i),
        .target_i      (target),
        .reached_o     (reached),
        .frame_start_o (frame_start)
    );

    copper_ctrl ctrl_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .enable_i      (enable_i),
        .frame_start_i (frame_start),
        .reached_i     (reached),
        .instr_i       (instr),
        .fetch_addr_o  (fetch_addr),
        .target_o      (target),
        .reg_wr_o      (reg_wr_o)
    );

endmodule

`default_nettype wire

//--- bench/copper_properties.sv
//**************************************************************************
// copper control properties
// write strobe and enable rules, bound into the control FSM
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

module copper_properties (
    input wire logic                    clk,
    input wire logic                    rst_n_i,
    input wire logic                    enable_i,
    input wire copper_pkg::ctrl_state_e state_i,
    input wire copper_pkg::reg_wr_t     reg_wr_i
);

    // read by the testbench for its verdict
    int fail_count;

    initial begin
        fail_count = 0;
    end

    valid_low_in_reset: assert property (@(posedge clk) !rst_n_i |=> !reg_wr_i.valid)
        else begin
            fail_count++;
            $error("register write strobe high after a reset cycle");
        end

    // strobe is a single cycle per MOVE
    valid_single_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        reg_wr_i.valid |=> !reg_wr_i.valid)
        else begin
            fail_count++;
            $error("register write strobe high for two cycles in a row");
        end

    idle_when_disabled: assert property (@(posedge clk) disable iff (!rst_n_i)
        !enable_i |=> (state_i == copper_pkg::IDLE))
        else begin
            fail_count++;
            $error("control FSM left IDLE while enable was low");
        end

endmodule

bind copper_ctrl copper_properties props_i (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .enable_i (enable_i),
    .state_i  (state_q),
    .reg_wr_i (reg_wr_o)
);

`default_nettype wire

//--- bench/copper_checker.sv
//**************************************************************************
// copper register write checker
// compares every register write strobe with the expected list in order
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

module copper_checker (
    input wire logic                  clk,
    input wire logic                  rst_n_i,
    input wire copper_pkg::beam_pos_t beam_i,
    input wire copper_pkg::reg_wr_t   reg_wr_i
);

    localparam int MAX_EXP = 32;

    copper_pkg::reg_num_t  exp_num  [0:MAX_EXP-1];
    copper_pkg::word_t     exp_data [0:MAX_EXP-1];
    copper_pkg::beam_pos_t exp_pos  [0:MAX_EXP-1];
    int                    exp_count;
    int                    exp_next;
    int                    error_count;
    int                    checked_count;

    initial begin
        exp_count     = 0;
        exp_next      = 0;
        error_count   = 0;
        checked_count = 0;
    end

    // later line, or same line with h at or past the earliest h
    function automatic bit beam_not_before(input copper_pkg::beam_pos_t pos,
                                           input copper_pkg::beam_pos_t earliest);
        return (pos.v > earliest.v) || ((pos.v == earliest.v) && (pos.h >= earliest.h));
    endfunction

    function automatic int pending_count();
        return exp_count - exp_next;
    endfunction

    task automatic clear_expected();
        exp_count = 0;
        exp_next  = 0;
    endtask

    task automatic push_expected(input copper_pkg::reg_num_t num,
                                 input copper_pkg::word_t data, input int v, input int h);
        if (exp_count < MAX_EXP) begin
            exp_num[exp_count]   = num;
            exp_data[exp_count]  = data;
            exp_pos[exp_count].v = copper_pkg::beam_coord_t'(v);
            exp_pos[exp_count].h = copper_pkg::beam_coord_t'(h);
            exp_count++;
        end
    endtask

    task automatic note_missing(input logic [8*24-1:0] name);
        $display("test %0s: %0d expected register writes never appeared",
                 name, pending_count());
        error_count += pending_count();
        exp_next = exp_count;
    endtask

    always @(posedge clk) begin
        if (rst_n_i && reg_wr_i.valid) begin
            if (exp_next >= exp_count) begin
                $display("ERROR at %0t ns: unexpected write reg 0x%02h data 0x%04h",
                         $time, reg_wr_i.num, reg_wr_i.data);
                error_count++;
            end else begin
                if (reg_wr_i.num !== exp_num[exp_next] ||
                    reg_wr_i.data !== exp_data[exp_next]) begin
                    $display("ERROR at %0t ns: write %0d got reg 0x%02h data 0x%04h, %s",
                             $time, exp_next, reg_wr_i.num, reg_wr_i.data,
                             $sformatf("expected reg 0x%02h data 0x%04h",
                                       exp_num[exp_next], exp_data[exp_next]));
                    error_count++;
                end
                if (!beam_not_before(beam_i, exp_pos[exp_next])) begin
                    $display("ERROR at %0t ns: write %0d at beam v=%0d h=%0d, before v=%0d h=%0d",
                             $time, exp_next, beam_i.v, beam_i.h,
                             exp_pos[exp_next].v, exp_pos[exp_next].h);
                    error_count++;
                end
                exp_next++;
                checked_count++;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/copper_tb.sv
//**************************************************************************
// copper testbench
// loads programs from the cases file, runs frames of a small beam raster
// and lets the checker compare the register writes
//**************************************************************************

`default_nettype none
`timescale 1ns/10ps

module copper_tb;

    localparam int FRAME_CYCLES = 32 * 16;
    localparam int MAX_WORDS    = 64;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  enable;
    copper_pkg::beam_pos_t beam;
    copper_pkg::host_wr_t  host_wr;
    copper_pkg::reg_wr_t   reg_wr;

    integer seed;
    int     frame_cnt;
    bit     timed_out;
    bit     file_error;
    int     tests_run;
    int     tests_failed;

    copper_top dut_i (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .enable_i  (enable),
        .beam_i    (beam),
        .host_wr_i (host_wr),
        .reg_wr_o  (reg_wr)
    );

    copper_checker checker_i (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .beam_i   (beam),
        .reg_wr_i (reg_wr)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // 32 columns by 16 lines at one position per cycle
    always @(negedge clk) begin
        if (beam.h == 31) begin
            beam.h <= '0;
            if (beam.v == 15) begin
                beam.v    <= '0;
                frame_cnt <= frame_cnt + 1;
            end else begin
                beam.v <= beam.v + 1'b1;
            end
        end else begin
            beam.h <= beam.h + 1'b1;
        end
    end

    task automatic write_word(input copper_pkg::host_addr_t addr, input copper_pkg::word_t data);
        int gap;
        @(negedge clk);
        host_wr = '{en: 1'b1, addr: addr, data: data};
        @(negedge clk);
        host_wr.en = 1'b0;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clk);
    endtask

    // counts wraps of the beam to the origin
    task automatic wait_frames(input int count);
        int target;
        int cycles;
        target = frame_cnt + count;
        cycles = 0;
        while (frame_cnt != target && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles > (count + 1) * FRAME_CYCLES) begin
                $display("timed out after %0d cycles waiting for %0d frame starts",
                         cycles, count);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_writes_done(input logic [8*24-1:0] name);
        int cycles;
        cycles = 0;
        while (checker_i.pending_count() != 0 && cycles < 32) begin
            @(negedge clk);
            cycles++;
        end
        if (checker_i.pending_count() != 0) begin
            checker_i.note_missing(name);
        end
    endtask

    task automatic run_test(input int fd);
        logic [8*24-1:0]      name;
        int                   nwords;
        int                   frames;
        int                   nwrites;
        int                   code;
        int                   errs_before;
        int                   v;
        int                   h;
        copper_pkg::word_t    words [0:MAX_WORDS-1];
        copper_pkg::reg_num_t w_num;
        copper_pkg::word_t    w_data;
        code = $fscanf(fd, "%s %d %d %d", name, nwords, frames, nwrites);
        if (code != 4 || nwords > MAX_WORDS || nwrites > 32) begin
            $display("cases file has a malformed test record");
            file_error = 1'b1;
            return;
        end
        for (int i = 0; i < nwords; i++) begin
            code = $fscanf(fd, "%h", words[i]);
            if (code != 1) begin
                file_error = 1'b1;
            end
        end
        checker_i.clear_expected();
        for (int i = 0; i < nwrites; i++) begin
            code = $fscanf(fd, "%h %h %d %d", w_num, w_data, v, h);
            if (code != 4) begin
                file_error = 1'b1;
            end
            checker_i.push_expected(w_num, w_data, v, h);
        end
        if (file_error) begin
            $display("cases file ends inside a test record");
            return;
        end
        errs_before = checker_i.error_count;
        for (int i = 0; i < nwords; i++) begin
            write_word(copper_pkg::host_addr_t'(i), words[i]);
        end
        // a frame start passes while disabled
        wait_frames(1);
        enable = 1'b1;
        // first wrap starts the copper, then the requested frames run
        wait_frames(frames + 1);
        enable = 1'b0;
        wait_writes_done(name);
        tests_run++;
        if (checker_i.error_count != errs_before) begin
            tests_failed++;
        end
        $display("test %0s: %0d frames, %0d writes expected, %0d errors",
                 name, frames, nwrites, checker_i.error_count - errs_before);
    endtask

    initial begin
        int              fd;
        int              code;
        bit              at_end;
        logic [8*8-1:0]  tok;
        logic [8*80-1:0] rest;
        seed         = 86;
        timed_out    = 1'b0;
        file_error   = 1'b0;
        at_end       = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        frame_cnt    = 0;
        beam         = '0;
        enable       = 1'b0;
        host_wr      = '0;
        rst_n        = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("bench/copper_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/copper_cases.txt for reading");
            file_error = 1'b1;
        end
        while (!file_error && !timed_out && !at_end) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                at_end = 1'b1;
            end else if (tok == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "test") begin
                run_test(fd);
            end else begin
                $display("cases file has an unknown record type");
                file_error = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("%0d tests run, %0d failed, %0d writes checked, %0d errors, %0d assert fails",
                 tests_run, tests_failed, checker_i.checked_count, checker_i.error_count,
                 dut_i.ctrl_i.props_i.fail_count);
        if (file_error || timed_out || tests_run == 0 || checker_i.error_count != 0 ||
            dut_i.ctrl_i.props_i.fail_count != 0) begin
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
rtl/copper_pkg.sv
rtl/coppermem.sv
rtl/copper_prog_mem.sv
rtl/copper_beam_cmp.sv
rtl/copper_ctrl.sv
rtl/copper_top.sv
bench/copper_properties.sv
bench/copper_checker.sv
bench/copper_tb.sv

//--- bench/copper_cases.txt
# test <name> <host words> <frames> <expected writes>, then host words in hex
# then one line per write: reg (hex) data (hex) earliest v h (decimal)
test idle 0 1 0
test moves 8 1 3
2010 1234 2011 abcd 2012 5a5a 07ff 07ff
10 1234 0 0
11 abcd 0 0
12 5a5a 0 0
test wait 12 1 3
2020 0001 0003 0005 2021 0002 0008 000a 2022 0003 07ff 07ff
20 0001 0 0
21 0002 3 5
22 0003 8 10
test skip 14 1 2
0002 0000 1001 0010 2030 dead 2031 0031 100c 0000 2032 0032 07ff 07ff
31 0031 2 0
32 0032 2 0
test jump 12 1 2
2040 0040 3000 0004 2041 bad1 2042 bad2 2043 0043 07ff 07ff
40 0040 0 0
43 0043 0 0
test repeat 10 2 4
0004 0000 2050 0050 0009 0010 2051 0051 07ff 07ff
50 0050 4 0
51 0051 9 16
50 0050 4 0
51 0051 9 16
